//--- btb_pkg.sv
// Shared definitions for the BTB fetch front end
// Address fields, vector types, info record layout, selector states

package btb_pkg;

  // --------------------
  // Address layout
  localparam int VADDR_W    = 32;
  localparam int LINE_BYTES = 16;
  localparam int SLOT_NUM   = 8;    // Halfword slots per line
  localparam int SLOT_LSB   = 1;
  localparam int SLOT_MSB   = 3;
  localparam int INDEX_LSB  = 4;
  localparam int INDEX_MSB  = 9;
  localparam int ENTRY_NUM  = 64;   // Entries per bank
  localparam int TAG_LSB    = INDEX_MSB + 1;
  localparam int TAG_W      = VADDR_W - TAG_LSB;

  typedef logic [VADDR_W-1:0]           vaddr_t;
  typedef logic [SLOT_MSB-SLOT_LSB:0]   slot_t;
  typedef logic [INDEX_MSB-INDEX_LSB:0] index_t;
  typedef logic [TAG_W-1:0]             tag_t;
  typedef logic [SLOT_NUM-1:0]          slot_mask_t;

  // --------------------
  // Info record, valid at the top and tag at the bottom
  localparam int INFO_TAG_LSB   = 0;
  localparam int INFO_TAG_MSB   = TAG_W - 1;
  localparam int INFO_RET_BIT   = TAG_W;
  localparam int INFO_CALL_BIT  = TAG_W + 1;
  localparam int INFO_COND_BIT  = TAG_W + 2;
  localparam int INFO_VALID_BIT = TAG_W + 3;
  localparam int INFO_W         = TAG_W + 4;

  typedef logic [INFO_W-1:0] info_t;

  // --------------------
  // Target selector
  localparam int SQUASH_CYCLES = 2;   // Lines still in flight behind a redirect
  localparam int SQUASH_CNT_W  = $clog2(SQUASH_CYCLES + 1);

  typedef enum logic {
    RUN,
    SQUASH
  } sel_state_t;

endpackage

//--- btb_update_if.sv
// Resolved branch update bundle
// Master drives one update strobe, BTB is the slave

interface btb_update_if
  import btb_pkg::*;
();

  logic   valid;          // One-cycle strobe
  vaddr_t pc_vaddr;
  vaddr_t target_vaddr;
  logic   taken;
  logic   mispredict;
  logic   is_cond;
  logic   is_call;
  logic   is_ret;
  logic   is_rvc;         // Compressed 16-bit instruction

  modport master (
    output valid, pc_vaddr, target_vaddr, taken, mispredict,
    output is_cond, is_call, is_ret, is_rvc
  );

  modport slave (
    input valid, pc_vaddr, target_vaddr, taken, mispredict,
    input is_cond, is_call, is_ret, is_rvc
  );

endinterface

//--- btb_search_if.sv
// BTB search bundle
// s0 request from the sequencer, per-slot s1 and s2 results from the BTB

interface btb_search_if
  import btb_pkg::*;
();

  // s0 request
  logic                  s0_valid;
  vaddr_t                s0_pc_vaddr;

  // s1 results, straight off the arrays
  slot_mask_t            s1_hit;
  vaddr_t [SLOT_NUM-1:0] s1_target_vaddr;
  slot_mask_t            s1_is_cond;
  slot_mask_t            s1_is_call;
  slot_mask_t            s1_is_ret;

  // s2 results, registered
  logic                  s2_valid;
  vaddr_t                s2_pc_vaddr;
  slot_mask_t            s2_hit;
  vaddr_t [SLOT_NUM-1:0] s2_target_vaddr;
  slot_mask_t            s2_is_cond;
  slot_mask_t            s2_is_call;
  slot_mask_t            s2_is_ret;

  modport requester (output s0_valid, s0_pc_vaddr);

  modport slave (
    input  s0_valid, s0_pc_vaddr,
    output s1_hit, s1_target_vaddr, s1_is_cond, s1_is_call, s1_is_ret,
    output s2_valid, s2_pc_vaddr, s2_hit, s2_target_vaddr,
    output s2_is_cond, s2_is_call, s2_is_ret
  );

  modport reader (
    input s2_valid, s2_pc_vaddr, s2_hit, s2_target_vaddr, s2_is_call, s2_is_ret
  );

endinterface

//--- btb_data_array.sv
// Behavioural two-port data array
// One write port, one synchronous read port, ENTRY_NUM words

module btb_data_array
  import btb_pkg::*;
#(
  parameter type data_t = info_t
) (
  input  logic   i_clk,
  input  logic   i_reset_n,
  input  logic   i_wr,
  input  index_t i_wr_addr,
  input  data_t  i_wr_data,
  input  index_t i_rd_addr,
  output data_t  o_rd_data
);

  data_t r_mem [ENTRY_NUM];

  // Read data one cycle after the address, old word on a same-cycle write
  always_ff @(posedge i_clk) begin
    if (i_wr && i_reset_n) begin    // No writes while in reset
      r_mem[i_wr_addr] <= i_wr_data;
    end
    o_rd_data <= r_mem[i_rd_addr];
  end

endmodule

//--- btb.sv
// Banked branch target buffer
// One info bank and one target bank per halfword slot
// Two-stage search: array read in s1, results registered into s2

module btb
  import btb_pkg::*;
(
  input logic         i_clk,
  input logic         i_reset_n,
  btb_update_if.slave update_if,
  btb_search_if.slave search_if
);

  // --------------------
  // Update side

  logic [VADDR_W-1:1] w_upd_hw;       // Halfword address that owns the record
  slot_t              w_upd_slot;
  index_t             w_upd_index;
  info_t              w_upd_info;
  logic               w_upd_tgt_ok;

  // A 32-bit instruction goes with its upper halfword, so a branch that
  // crosses a line is found when the upper line is fetched
  assign w_upd_hw    = update_if.pc_vaddr[VADDR_W-1:1] + (VADDR_W-1)'(!update_if.is_rvc);
  assign w_upd_slot  = w_upd_hw[SLOT_MSB:SLOT_LSB];
  assign w_upd_index = w_upd_hw[INDEX_MSB:INDEX_LSB];

  // Target only for taken branches that missed, calls and returns
  assign w_upd_tgt_ok = update_if.taken &
                        (update_if.mispredict | update_if.is_call | update_if.is_ret);

  always_comb begin
    w_upd_info[INFO_VALID_BIT]            = 1'b1;
    w_upd_info[INFO_COND_BIT]             = update_if.is_cond;
    w_upd_info[INFO_CALL_BIT]             = update_if.is_call;
    w_upd_info[INFO_RET_BIT]              = update_if.is_ret;
    w_upd_info[INFO_TAG_MSB:INFO_TAG_LSB] = w_upd_hw[VADDR_W-1:TAG_LSB];
  end

  // --------------------
  // s0 to s1

  slot_t      w_s0_slot;
  index_t     w_s0_index;
  logic       r_s1_valid;
  vaddr_t     r_s1_pc_vaddr;
  slot_mask_t r_s1_mask;              // Slots at or after the fetch offset
  tag_t       w_s1_tag;

  assign w_s0_slot  = search_if.s0_pc_vaddr[SLOT_MSB:SLOT_LSB];
  assign w_s0_index = search_if.s0_pc_vaddr[INDEX_MSB:INDEX_LSB];
  assign w_s1_tag   = r_s1_pc_vaddr[VADDR_W-1:TAG_LSB];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s1_mask  <= '0;
    end else begin
      r_s1_valid <= search_if.s0_valid;
      r_s1_mask  <= ~((slot_mask_t'(1) << w_s0_slot) - slot_mask_t'(1));
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_pc_vaddr <= search_if.s0_pc_vaddr;
  end

  // --------------------
  // Per-slot banks

  for (genvar b = 0; b < SLOT_NUM; b++) begin : g_bank
    logic                 w_info_wr;
    logic                 w_tgt_wr;
    info_t                w_s1_info;
    vaddr_t               w_s1_target;
    logic [ENTRY_NUM-1:0] r_valid;          // Arrays themselves are not reset
    logic                 r_s1_bank_valid;

    assign w_info_wr = update_if.valid & (w_upd_slot == slot_t'(b));
    assign w_tgt_wr  = w_info_wr & w_upd_tgt_ok;

    btb_data_array #(.data_t(info_t)) u_info_array (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_wr      (w_info_wr),
      .i_wr_addr (w_upd_index),
      .i_wr_data (w_upd_info),
      .i_rd_addr (w_s0_index),
      .o_rd_data (w_s1_info)
    );

    btb_data_array #(.data_t(vaddr_t)) u_target_array (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_wr      (w_tgt_wr),
      .i_wr_addr (w_upd_index),
      .i_wr_data (update_if.target_vaddr),
      .i_rd_addr (w_s0_index),
      .o_rd_data (w_s1_target)
    );

    always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_valid         <= '0;
        r_s1_bank_valid <= 1'b0;
      end else begin
        if (w_info_wr) begin
          r_valid[w_upd_index] <= 1'b1;
        end
        r_s1_bank_valid <= r_valid[w_s0_index];   // Sampled before this edge's write
      end
    end

    assign search_if.s1_hit[b] = r_s1_valid & r_s1_bank_valid & r_s1_mask[b] &
                                 w_s1_info[INFO_VALID_BIT] &
                                 (w_s1_info[INFO_TAG_MSB:INFO_TAG_LSB] == w_s1_tag);

    assign search_if.s1_target_vaddr[b] = w_s1_target;
    assign search_if.s1_is_cond[b]      = r_s1_bank_valid & w_s1_info[INFO_COND_BIT];
    assign search_if.s1_is_call[b]      = r_s1_bank_valid & w_s1_info[INFO_CALL_BIT];
    assign search_if.s1_is_ret[b]       = r_s1_bank_valid & w_s1_info[INFO_RET_BIT];
  end

  // --------------------
  // s1 to s2

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      search_if.s2_valid <= 1'b0;
      search_if.s2_hit   <= '0;
    end else begin
      search_if.s2_valid <= r_s1_valid;
      search_if.s2_hit   <= search_if.s1_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    search_if.s2_pc_vaddr     <= r_s1_pc_vaddr;
    search_if.s2_target_vaddr <= search_if.s1_target_vaddr;
    search_if.s2_is_cond      <= search_if.s1_is_cond;
    search_if.s2_is_call      <= search_if.s1_is_call;
    search_if.s2_is_ret       <= search_if.s1_is_ret;
  end

endmodule

//--- fetch_pc_seq.sv
// Fetch sequencer
// Issues one line per cycle into the BTB search, follows redirects

module fetch_pc_seq
  import btb_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_start,
  input  vaddr_t                 i_start_pc,
  input  logic                   i_stop,
  input  logic                   i_redirect,
  input  vaddr_t                 i_redirect_pc,
  btb_search_if.requester        search_if
);

  logic   r_running;
  vaddr_t r_pc;              // Keeps its offset until the next line
  vaddr_t w_next_line;

  assign w_next_line = (r_pc & ~vaddr_t'(LINE_BYTES - 1)) + vaddr_t'(LINE_BYTES);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_running <= 1'b0;
      r_pc      <= '0;
    end else if (i_start) begin
      r_running <= 1'b1;
      r_pc      <= i_start_pc;
    end else if (i_stop) begin
      r_running <= 1'b0;
    end else if (r_running) begin
      // Redirect target keeps its offset
      r_pc <= i_redirect ? i_redirect_pc : w_next_line;
    end
  end

  assign search_if.s0_valid    = r_running;
  assign search_if.s0_pc_vaddr = r_pc;

endmodule

//--- btb_target_select.sv
// BTB target selector
// Lowest hitting slot wins, redirect on a hit, squash of lines in flight
// Registered prediction output, one per reported line

module btb_target_select
  import btb_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,
  btb_search_if.reader        search_if,
  output logic                o_redirect,
  output vaddr_t              o_redirect_pc,
  output logic                o_pred_valid,
  output vaddr_t              o_pred_pc,
  output logic                o_pred_hit,
  output slot_t               o_pred_slot,
  output vaddr_t              o_pred_target,
  output logic                o_pred_is_call,
  output logic                o_pred_is_ret
);

  sel_state_t              r_state;
  logic [SQUASH_CNT_W-1:0] r_squash_cnt;
  logic                    w_live;        // s2 line is reported
  logic                    w_any_hit;
  slot_t                   w_sel_slot;
  vaddr_t                  w_sel_target;
  vaddr_t                  w_next_pc;

  // --------------------
  // Slot priority

  always_comb begin
    w_sel_slot = '0;
    for (int i = SLOT_NUM - 1; i >= 0; i--) begin
      if (search_if.s2_hit[i]) begin
        w_sel_slot = slot_t'(i);
      end
    end
  end

  assign w_any_hit    = |search_if.s2_hit;
  assign w_sel_target = search_if.s2_target_vaddr[w_sel_slot];
  assign w_live       = search_if.s2_valid & (r_state == RUN);

  // Next fetch PC: target on a hit, else the following aligned line
  assign w_next_pc = w_any_hit ? w_sel_target :
                     (search_if.s2_pc_vaddr & ~vaddr_t'(LINE_BYTES - 1)) +
                     vaddr_t'(LINE_BYTES);

  assign o_redirect    = w_live & w_any_hit;
  assign o_redirect_pc = w_sel_target;

  // --------------------
  // Squash FSM

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state      <= RUN;
      r_squash_cnt <= '0;
      o_pred_valid <= 1'b0;
    end else begin
      o_pred_valid <= w_live;
      case (r_state)
        RUN: begin
          if (o_redirect) begin
            r_state      <= SQUASH;
            r_squash_cnt <= SQUASH_CNT_W'(SQUASH_CYCLES);
          end
        end
        SQUASH: begin
          r_squash_cnt <= r_squash_cnt - 1'b1;   // One line dropped per cycle
          if (r_squash_cnt == SQUASH_CNT_W'(1)) begin
            r_state <= RUN;
          end
        end
        default: r_state <= RUN;
      endcase
    end
  end

  // Prediction payload
  always_ff @(posedge i_clk) begin
    if (w_live) begin
      o_pred_pc      <= search_if.s2_pc_vaddr;
      o_pred_hit     <= w_any_hit;
      o_pred_slot    <= w_sel_slot;
      o_pred_target  <= w_next_pc;
      o_pred_is_call <= w_any_hit & search_if.s2_is_call[w_sel_slot];
      o_pred_is_ret  <= w_any_hit & search_if.s2_is_ret[w_sel_slot];
    end
  end

endmodule

//--- btb_top.sv
// Fetch predictor front end, top level
// Sequencer, banked BTB and target selector with their interface wiring

module btb_top
  import btb_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_reset_n,

  // Fetch control
  input  logic   i_start,
  input  vaddr_t i_start_pc,
  input  logic   i_stop,

  // Resolved branch updates
  input  logic   i_upd_valid,
  input  vaddr_t i_upd_pc,
  input  vaddr_t i_upd_target,
  input  logic   i_upd_taken,
  input  logic   i_upd_mispredict,
  input  logic   i_upd_is_cond,
  input  logic   i_upd_is_call,
  input  logic   i_upd_is_ret,
  input  logic   i_upd_is_rvc,

  // Predictions
  output logic   o_pred_valid,
  output vaddr_t o_pred_pc,
  output logic   o_pred_hit,
  output slot_t  o_pred_slot,
  output vaddr_t o_pred_target,
  output logic   o_pred_is_call,
  output logic   o_pred_is_ret
);

  btb_update_if update_if ();
  btb_search_if search_if ();

  logic   w_redirect;
  vaddr_t w_redirect_pc;

  assign update_if.valid        = i_upd_valid;
  assign update_if.pc_vaddr     = i_upd_pc;
  assign update_if.target_vaddr = i_upd_target;
  assign update_if.taken        = i_upd_taken;
  assign update_if.mispredict   = i_upd_mispredict;
  assign update_if.is_cond      = i_upd_is_cond;
  assign update_if.is_call      = i_upd_is_call;
  assign update_if.is_ret       = i_upd_is_ret;
  assign update_if.is_rvc       = i_upd_is_rvc;

  fetch_pc_seq u_seq (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_start       (i_start),
    .i_start_pc    (i_start_pc),
    .i_stop        (i_stop),
    .i_redirect    (w_redirect),
    .i_redirect_pc (w_redirect_pc),
    .search_if     (search_if.requester)
  );

  btb u_btb (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .update_if (update_if.slave),
    .search_if (search_if.slave)
  );

  btb_target_select u_sel (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .search_if      (search_if.reader),
    .o_redirect     (w_redirect),
    .o_redirect_pc  (w_redirect_pc),
    .o_pred_valid   (o_pred_valid),
    .o_pred_pc      (o_pred_pc),
    .o_pred_hit     (o_pred_hit),
    .o_pred_slot    (o_pred_slot),
    .o_pred_target  (o_pred_target),
    .o_pred_is_call (o_pred_is_call),
    .o_pred_is_ret  (o_pred_is_ret)
  );

endmodule

//--- tb_btb_top.sv
// Directed testbench for the BTB fetch front end
// Reference BTB model, prediction monitor, compare tasks
// Directed tests, random update stream, cycle timeout

module tb_btb_top
  import btb_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // --------------------
  // Run lengths
  localparam int RESET_CYCLES = 8;
  localparam int DRAIN_LIMIT  = 12;   // Cycles to wait for the last predictions
  localparam int RUN_OVH      = 24;   // Start, drain and settle of one run
  localparam int RND_ROUNDS   = 6;
  localparam int RND_UPDATES  = 6;
  localparam int RND_LINES    = 24;

  localparam int LEN_EMPTY    = 6 + RUN_OVH;
  localparam int LEN_TAKEN    = 1 + 8 + RUN_OVH;
  localparam int LEN_OFFSET   = 3 + 8 + 4 + 2 * RUN_OVH;
  localparam int LEN_PRIORITY = 3 + 3 * (5 + RUN_OVH);
  localparam int LEN_RANDOM   = RND_ROUNDS * (RND_UPDATES + RND_LINES + RUN_OVH);
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + LEN_EMPTY + LEN_TAKEN + LEN_OFFSET +
                                  LEN_PRIORITY + LEN_RANDOM + 200;

  typedef struct packed {
    vaddr_t pc;
    logic   hit;
    slot_t  slot;
    vaddr_t target;
    logic   is_call;
    logic   is_ret;
  } pred_t;

  logic   i_clk;
  logic   i_reset_n;
  logic   i_start;
  vaddr_t i_start_pc;
  logic   i_stop;
  logic   i_upd_valid;
  vaddr_t i_upd_pc;
  vaddr_t i_upd_target;
  logic   i_upd_taken;
  logic   i_upd_mispredict;
  logic   i_upd_is_cond;
  logic   i_upd_is_call;
  logic   i_upd_is_ret;
  logic   i_upd_is_rvc;
  logic   o_pred_valid;
  vaddr_t o_pred_pc;
  logic   o_pred_hit;
  slot_t  o_pred_slot;
  vaddr_t o_pred_target;
  logic   o_pred_is_call;
  logic   o_pred_is_ret;

  int          value_errors = 0;
  int          other_errors = 0;
  int          cycle_count  = 0;
  logic [31:0] rng_state;
  pred_t       exp_q [$];
  pred_t       got_q [$];
  pred_t       mon_pred;

  // Reference BTB, keyed by address bits 9:1 of the recorded halfword
  tag_t   m_tag    [int];
  logic   m_call   [int];
  logic   m_ret    [int];
  vaddr_t m_target [int];

  btb_top btb_top_i (.*);

  always #2 i_clk = ~i_clk;

  // Predictions in order of appearance
  always @(negedge i_clk) begin
    if (i_reset_n && o_pred_valid === 1'b1) begin
      mon_pred.pc      = o_pred_pc;
      mon_pred.hit     = o_pred_hit;
      mon_pred.slot    = o_pred_slot;
      mon_pred.target  = o_pred_target;
      mon_pred.is_call = o_pred_is_call;
      mon_pred.is_ret  = o_pred_is_ret;
      got_q.push_back(mon_pred);
    end
  end

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      other_errors++;
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
      $display("Verification failed");
      $finish;
    end
  end

  // --------------------
  // Model and helpers

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // A 32-bit instruction belongs to its upper halfword
  function automatic vaddr_t record_halfword(vaddr_t pc, logic rvc);
    vaddr_t hw;
    hw = {pc[31:1], 1'b0};
    return rvc ? hw : hw + 32'd2;
  endfunction

  function automatic void record_update(vaddr_t pc, vaddr_t target, logic taken,
                                        logic mispredict, logic call, logic ret, logic rvc);
    vaddr_t a;
    int     key;
    a           = record_halfword(pc, rvc);
    key         = int'(a[9:1]);
    m_tag[key]  = a[31:10];
    m_call[key] = call;
    m_ret[key]  = ret;
    if (taken && (mispredict || call || ret)) begin
      m_target[key] = target;
    end
  endfunction

  // First recorded slot at or after the offset with a matching tag
  function automatic pred_t predict_line(vaddr_t pc);
    pred_t  p;
    vaddr_t line;
    vaddr_t a;
    int     key;
    line      = pc & ~vaddr_t'(LINE_BYTES - 1);
    p.pc      = pc;
    p.hit     = 1'b0;
    p.slot    = '0;
    p.target  = line + vaddr_t'(LINE_BYTES);
    p.is_call = 1'b0;
    p.is_ret  = 1'b0;
    for (int s = int'(pc[3:1]); s < SLOT_NUM; s++) begin
      a   = line + vaddr_t'(2 * s);
      key = int'(a[9:1]);
      if (!p.hit && m_tag.exists(key) && m_tag[key] == a[31:10]) begin
        p.hit     = 1'b1;
        p.slot    = slot_t'(s);
        p.is_call = m_call[key];
        p.is_ret  = m_ret[key];
        if (m_target.exists(key)) begin
          p.target = m_target[key];
        end else begin
          other_errors++;
          $display("Model holds a branch at %h without a known target", a);
        end
      end
    end
    return p;
  endfunction

  // --------------------
  // Compare tasks

  task automatic check_vaddr(input string name, input vaddr_t expected, input vaddr_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("[ERROR] %0.1f ns: %s expected %h, got %h", $realtime, name, expected, actual);
    end
  endtask

  task automatic check_slot(input string name, input slot_t expected, input slot_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("[ERROR] %0.1f ns: %s expected %0d, got %0d", $realtime, name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("[ERROR] %0.1f ns: %s expected %b, got %b", $realtime, name, expected, actual);
    end
  endtask

  task automatic compare_predictions();
    int n;
    if (got_q.size() != exp_q.size()) begin
      value_errors++;
      $display("[ERROR] %0.1f ns: prediction count expected %0d, got %0d",
               $realtime, exp_q.size(), got_q.size());
    end
    n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      check_vaddr("o_pred_pc", exp_q[i].pc, got_q[i].pc);
      check_flag("o_pred_hit", exp_q[i].hit, got_q[i].hit);
      if (exp_q[i].hit) begin
        check_slot("o_pred_slot", exp_q[i].slot, got_q[i].slot);
      end
      check_vaddr("o_pred_target", exp_q[i].target, got_q[i].target);
      check_flag("o_pred_is_call", exp_q[i].is_call, got_q[i].is_call);
      check_flag("o_pred_is_ret", exp_q[i].is_ret, got_q[i].is_ret);
    end
  endtask

  // --------------------
  // Drivers, entered and left 0.5 ns after a rising edge

  task automatic apply_update(input vaddr_t pc, input vaddr_t target, input logic taken,
                              input logic mispredict, input logic cond, input logic call,
                              input logic ret, input logic rvc);
    i_upd_valid      = 1'b1;
    i_upd_pc         = pc;
    i_upd_target     = target;
    i_upd_taken      = taken;
    i_upd_mispredict = mispredict;
    i_upd_is_cond    = cond;
    i_upd_is_call    = call;
    i_upd_is_ret     = ret;
    i_upd_is_rvc     = rvc;
    @(posedge i_clk);
    #0.5;
    i_upd_valid = 1'b0;
    record_update(pc, target, taken, mispredict, call, ret, rvc);
  endtask

  // Issues n_lines s0 slots, a hit costs SQUASH_CYCLES dropped slots
  task automatic run_fetch(input vaddr_t start_pc, input int n_lines);
    pred_t  p;
    vaddr_t pc;
    int     pos;
    int     waited;
    exp_q.delete();
    got_q.delete();
    pc  = start_pc;
    pos = 0;
    while (pos < n_lines) begin
      p = predict_line(pc);
      exp_q.push_back(p);
      pos = pos + (p.hit ? 1 + SQUASH_CYCLES : 1);
      pc  = p.target;
    end
    i_start_pc = start_pc;
    i_start    = 1'b1;
    @(posedge i_clk);
    #0.5;
    i_start = 1'b0;
    repeat (n_lines - 1) begin
      @(posedge i_clk);
      #0.5;
    end
    i_stop = 1'b1;
    @(posedge i_clk);
    #0.5;
    i_stop = 1'b0;
    waited = 0;
    while (got_q.size() < exp_q.size() && waited < DRAIN_LIMIT) begin
      @(posedge i_clk);
      waited++;
    end
    repeat (4) @(posedge i_clk);   // Room for any extra prediction
    #0.5;
    compare_predictions();
  endtask

  // --------------------
  // Tests

  task automatic empty_btb_run();
    $display("Test: empty BTB");
    run_fetch(32'h0000_1008, 6);
  endtask

  task automatic taken_branch_redirect();
    $display("Test: taken branch");
    apply_update(32'h0000_2046, 32'h0000_3104, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
    run_fetch(32'h0000_2020, 8);
  endtask

  task automatic offset_mask_and_target_rules();
    $display("Test: offset masking and target write rules");
    apply_update(32'h0000_3102, 32'h0000_5000, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
    // Taken but predicted right, old target stays
    apply_update(32'h0000_2046, 32'h0000_7000, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
    // Not taken and predicted right keeps the old target too
    apply_update(32'h0000_2046, 32'h0000_7100, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
    run_fetch(32'h0000_2020, 8);    // Slot 1 of line 3100 lies below offset 4
    run_fetch(32'h0000_3100, 4);
  endtask

  task automatic slot_priority_and_wide_branch();
    $display("Test: slot priority and 32-bit branches");
    apply_update(32'h0000_400a, 32'h0000_6000, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
    apply_update(32'h0000_4004, 32'h0000_6100, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
    apply_update(32'h0000_401e, 32'h0000_6200, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    run_fetch(32'h0000_4000, 4);
    run_fetch(32'h0000_4006, 4);
    run_fetch(32'h0000_4010, 5);
  endtask

  task automatic random_update_stream();
    logic [31:0] k;
    vaddr_t      pc;
    vaddr_t      tgt;
    vaddr_t      a;
    logic        taken;
    logic        mispredict;
    logic        call;
    logic        ret;
    $display("Test: random stream");
    for (int r = 0; r < RND_ROUNDS; r++) begin
      for (int u = 0; u < RND_UPDATES; u++) begin
        pc         = 32'h0000_8000 | (next_random() & 32'h0000_03fe);
        tgt        = 32'h0000_8000 | (next_random() & 32'h0000_03fe);
        k          = next_random();
        taken      = k[1];
        mispredict = k[2];
        call       = k[3] & ~k[4];
        ret        = k[4] & ~k[3];
        a          = record_halfword(pc, k[0]);
        // A fresh record needs a target
        if (!(taken && (mispredict || call || ret)) && !m_target.exists(int'(a[9:1]))) begin
          taken      = 1'b1;
          mispredict = 1'b1;
        end
        apply_update(pc, tgt, taken, mispredict, ~call & ~ret, call, ret, k[0]);
      end
      run_fetch(32'h0000_8000 | (next_random() & 32'h0000_03fe), RND_LINES);
    end
  endtask

  initial begin
    i_clk            = 1'b0;
    i_reset_n        = 1'b0;
    i_start          = 1'b0;
    i_start_pc       = '0;
    i_stop           = 1'b0;
    i_upd_valid      = 1'b0;
    i_upd_pc         = '0;
    i_upd_target     = '0;
    i_upd_taken      = 1'b0;
    i_upd_mispredict = 1'b0;
    i_upd_is_cond    = 1'b0;
    i_upd_is_call    = 1'b0;
    i_upd_is_ret     = 1'b0;
    i_upd_is_rvc     = 1'b0;
    rng_state        = 32'h918b;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #0.5;
    i_reset_n = 1'b1;
    @(posedge i_clk);
    #0.5;

    empty_btb_run();
    taken_branch_redirect();
    offset_mask_and_target_rules();
    slot_priority_and_wide_branch();
    random_update_stream();

    repeat (2) @(posedge i_clk);
    $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
btb_pkg.sv
btb_update_if.sv
btb_search_if.sv
btb_data_array.sv
btb.sv
fetch_pc_seq.sv
btb_target_select.sv
btb_top.sv
tb_btb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the BTB testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_btb_top -o tb_btb_top
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_btb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  echo "Testbench reported failure"
  exit 1
fi

if ! grep -q "Verification passed" "$LOG"; then
  echo "Testbench ended without a result"
  exit 1
fi

exit 0
